// ==== logic/scale_pkg.sv ====
// Datapath types for the block-floating-point normalizer
// Sample, shift code, shift magnitude, guard and headroom widths
// Clamp limit of the signed shift code

package scale_pkg;

    // Audio sample width in bits
    localparam int SAMPLE_W = 24;

    // Largest shift magnitude in either direction
    localparam int MAX_SHIFT = 15;

    // Two's-complement audio sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Signed shift code
    // Top bit set means shift left by the magnitude
    typedef logic [4:0] shift_code_t;

    // Shift magnitude, 0 to 15
    typedef logic [3:0] shift_amt_t;

    // Headroom bits requested for a block, 0 to 7
    typedef logic [2:0] guard_t;

    // Redundant sign bit count of a sample, 0 to 23
    typedef logic [4:0] headroom_t;

endpackage

// ==== logic/block_pkg.sv ====
// Block geometry and control machine encodings
// Block length, buffer index type, buffer and scaler state enums

package block_pkg;

    // Samples per block
    localparam int BLOCK_LEN = 8;

    // Index width into the block buffer
    localparam int ADDR_W = $clog2(BLOCK_LEN);

    // Buffer address, also the fill and drain position
    typedef logic [ADDR_W-1:0] addr_t;

    // Input side machine
    // FILL          waiting for in_req, block not yet complete
    // WAIT_ACK_LOW  in_ack high, waiting for in_req to drop
    // FULL          block stored, input held off until release
    typedef enum logic [1:0] {
        FILL         = 2'd0,
        WAIT_ACK_LOW = 2'd1,
        FULL         = 2'd2
    } buf_state_t;

    // Output side machine
    // IDLE      waiting for a complete block and its shift code
    // READ      scaled sample being registered
    // REQ_HIGH  out_req high, waiting for out_ack
    // REQ_LOW   out_req low, waiting for out_ack to drop
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        READ     = 2'd1,
        REQ_HIGH = 2'd2,
        REQ_LOW  = 2'd3
    } out_state_t;

endpackage

// ==== logic/capture_if.sv ====
// Write broadcast from the block buffer to the headroom detector
// One strobe per accepted sample with block position flags

interface capture_if;

    // One-cycle strobe per accepted sample
    logic                 wr_en;
    scale_pkg::sample_t   wr_sample;
    // First and last sample of the block
    logic                 wr_first;
    logic                 wr_last;
    // Guard of the block, meaningful with wr_first
    scale_pkg::guard_t    wr_guard;

    modport source (
        output wr_en, wr_sample, wr_first, wr_last, wr_guard
    );

    modport sink (
        input wr_en, wr_sample, wr_first, wr_last, wr_guard
    );

endinterface

// ==== logic/scale_if.sv ====
// Block exchange between buffer, headroom detector and scaler
// Block readiness, read port, shift code and block release

interface scale_if;

    // Buffer side: block stored, and the sample at rd_addr
    logic                 block_full;
    scale_pkg::sample_t   rd_data;

    // Detector side: shift code of the stored block
    scale_pkg::shift_code_t shift_code;
    logic                   shift_valid;

    // Scaler side: read address and end-of-block strobe
    block_pkg::addr_t     rd_addr;
    logic                 block_release;

    modport buffer (
        output block_full, rd_data,
        input  rd_addr, block_release
    );

    modport detector (
        output shift_code, shift_valid,
        input  block_release
    );

    modport scaler (
        input  block_full, rd_data, shift_code, shift_valid,
        output rd_addr, block_release
    );

endinterface

// ==== logic/block_buffer.sv ====
// Input four-phase handshake and eight-entry sample store
// Fill counter, write broadcast and block full flag

module block_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_req,
    input  scale_pkg::sample_t  in_sample,
    input  scale_pkg::guard_t   in_guard,
    output logic                in_ack,
    capture_if.source           cap,
    scale_if.buffer             blk
);

    block_pkg::buf_state_t state;
    block_pkg::addr_t      fill_cnt;
    logic                  accept;
    logic                  last_slot;

    // Sample storage, one block
    scale_pkg::sample_t mem [block_pkg::BLOCK_LEN];

    // A request is taken only while filling
    assign accept    = (state == block_pkg::FILL) && in_req;
    assign last_slot = (fill_cnt == block_pkg::addr_t'(block_pkg::BLOCK_LEN - 1));

    // Ack is high for exactly the wait-for-req-low phase
    assign in_ack = (state == block_pkg::WAIT_ACK_LOW);

    // Handshake and fill control
    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= block_pkg::FILL;
            fill_cnt       <= '0;
            blk.block_full <= 1'b0;
        end else begin
            case (state)
                block_pkg::FILL: begin
                    if (accept) begin
                        state    <= block_pkg::WAIT_ACK_LOW;
                        // Wraps to zero after the eighth sample
                        fill_cnt <= fill_cnt + 1'b1;
                        if (last_slot) begin
                            blk.block_full <= 1'b1;
                        end
                    end
                end
                block_pkg::WAIT_ACK_LOW: begin
                    if (!in_req) begin
                        // Release may already have come if the source was slow
                        if (blk.block_full && !blk.block_release) begin
                            state <= block_pkg::FULL;
                        end else begin
                            state <= block_pkg::FILL;
                        end
                    end
                end
                default: begin
                    // Input stays unanswered until the block drains
                    if (blk.block_release) begin
                        state <= block_pkg::FILL;
                    end
                end
            endcase

            if (blk.block_release) begin
                blk.block_full <= 1'b0;
            end
        end
    end

    // Sample memory write
    always_ff @(posedge clk) begin
        if (accept) begin
            mem[fill_cnt] <= in_sample;
        end
    end

    // Broadcast each accepted sample to the detector
    assign cap.wr_en     = accept;
    assign cap.wr_sample = in_sample;
    assign cap.wr_first  = (fill_cnt == '0);
    assign cap.wr_last   = last_slot;
    assign cap.wr_guard  = in_guard;

    // Asynchronous read port for the scaler
    assign blk.rd_data = mem[blk.rd_addr];

endmodule

// ==== logic/headroom_detect.sv ====
// Block headroom detector
// Minimum redundant sign bit count over a block
// Clamped signed shift code, guard minus headroom

module headroom_detect (
    input  logic       clk,
    input  logic       reset,
    capture_if.sink    cap,
    scale_if.detector  blk
);

    scale_pkg::headroom_t cur_hr;
    scale_pkg::headroom_t min_hr;
    scale_pkg::headroom_t min_next;
    scale_pkg::guard_t    guard_q;
    scale_pkg::guard_t    guard_sel;
    logic signed [6:0]    diff;
    scale_pkg::shift_code_t code_clamped;

    // Count bits below the sign bit that repeat it
    function automatic scale_pkg::headroom_t sign_bits(input scale_pkg::sample_t s);
        scale_pkg::headroom_t cnt;
        logic                 run;
        cnt = '0;
        run = 1'b1;
        for (int i = scale_pkg::SAMPLE_W - 2; i >= 0; i--) begin
            if (run && (s[i] == s[scale_pkg::SAMPLE_W-1])) begin
                cnt = cnt + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
        return cnt;
    endfunction

    assign cur_hr = sign_bits(cap.wr_sample);

    // Running minimum, restarted by the first sample
    assign min_next  = (cap.wr_first || (cur_hr < min_hr)) ? cur_hr : min_hr;
    assign guard_sel = cap.wr_first ? cap.wr_guard : guard_q;

    // Guard minus headroom, range -23 to +7 before the clamp
    assign diff = $signed({4'b0000, guard_sel}) - $signed({2'b00, min_next});

    always_comb begin
        if (diff < -scale_pkg::MAX_SHIFT) begin
            code_clamped = scale_pkg::shift_code_t'(-scale_pkg::MAX_SHIFT);
        end else if (diff > scale_pkg::MAX_SHIFT) begin
            code_clamped = scale_pkg::shift_code_t'(scale_pkg::MAX_SHIFT);
        end else begin
            code_clamped = diff[4:0];
        end
    end

    // Minimum and guard of the block in progress
    always_ff @(posedge clk) begin
        if (cap.wr_en) begin
            min_hr <= min_next;
            if (cap.wr_first) begin
                guard_q <= cap.wr_guard;
            end
        end
    end

    // Shift code held until the scaler releases the block
    always_ff @(posedge clk) begin
        if (reset) begin
            blk.shift_valid <= 1'b0;
        end else if (cap.wr_en && cap.wr_last) begin
            blk.shift_valid <= 1'b1;
        end else if (blk.block_release) begin
            blk.shift_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cap.wr_en && cap.wr_last) begin
            blk.shift_code <= code_clamped;
        end
    end

endmodule

// ==== logic/dynamic_scale.sv ====
// Block scaler with output four-phase handshake
// Signed shift decode, left or arithmetic right shift
// Block read-back sequencing and release strobe

module dynamic_scale (
    input  logic                    clk,
    input  logic                    reset,
    scale_if.scaler                 blk,
    output logic                    out_req,
    output scale_pkg::sample_t      out_sample,
    output scale_pkg::shift_code_t  out_shift,
    input  logic                    out_ack
);

    block_pkg::out_state_t state;
    logic                  shift_left;
    scale_pkg::shift_amt_t shift_amt;
    scale_pkg::sample_t    scaled;
    logic                  last_addr;

    // Sign gives direction, two's complement of the low bits gives magnitude
    assign shift_left = blk.shift_code[4];
    assign shift_amt  = shift_left ? (~blk.shift_code[3:0] + 4'd1) : blk.shift_code[3:0];

    // Right shift keeps the sign of negative samples
    always_comb begin
        if (shift_left) begin
            scaled = blk.rd_data << shift_amt;
        end else begin
            scaled = scale_pkg::sample_t'($signed(blk.rd_data) >>> shift_amt);
        end
    end

    assign last_addr = (blk.rd_addr == block_pkg::addr_t'(block_pkg::BLOCK_LEN - 1));

    // Request is high only while waiting for ack
    assign out_req = (state == block_pkg::REQ_HIGH);

    // Read-back and handshake sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= block_pkg::IDLE;
            blk.rd_addr       <= '0;
            blk.block_release <= 1'b0;
        end else begin
            blk.block_release <= 1'b0;
            case (state)
                block_pkg::IDLE: begin
                    // Flags still high during the release cycle itself
                    if (blk.block_full && blk.shift_valid && !blk.block_release) begin
                        state <= block_pkg::READ;
                    end
                end
                block_pkg::READ: begin
                    state <= block_pkg::REQ_HIGH;
                end
                block_pkg::REQ_HIGH: begin
                    if (out_ack) begin
                        state <= block_pkg::REQ_LOW;
                    end
                end
                default: begin
                    // Sink finishes the cycle by dropping ack
                    if (!out_ack) begin
                        blk.rd_addr <= blk.rd_addr + 1'b1;
                        if (last_addr) begin
                            state             <= block_pkg::IDLE;
                            blk.block_release <= 1'b1;
                        end else begin
                            state <= block_pkg::READ;
                        end
                    end
                end
            endcase
        end
    end

    // Output payload, stable from READ until the next read
    always_ff @(posedge clk) begin
        if (state == block_pkg::READ) begin
            out_sample <= scaled;
            out_shift  <= blk.shift_code;
        end
    end

endmodule

// ==== logic/block_scaler_top.sv ====
// Top level of the block-floating-point normalizer
// Buffer and headroom detector in parallel, scaler on the output side

module block_scaler_top (
    input  logic                    clk,
    input  logic                    reset,
    // Input handshake
    input  logic                    in_req,
    input  scale_pkg::sample_t      in_sample,
    input  scale_pkg::guard_t       in_guard,
    output logic                    in_ack,
    // Output handshake
    output logic                    out_req,
    output scale_pkg::sample_t      out_sample,
    output scale_pkg::shift_code_t  out_shift,
    input  logic                    out_ack
);

    // Sample writes seen by the detector
    capture_if cap_bus ();

    // Block state shared by all three blocks
    scale_if scl_bus ();

    // Stores the block and runs the input handshake
    block_buffer u_block_buffer (
        .clk       (clk),
        .reset     (reset),
        .in_req    (in_req),
        .in_sample (in_sample),
        .in_guard  (in_guard),
        .in_ack    (in_ack),
        .cap       (cap_bus.source),
        .blk       (scl_bus.buffer)
    );

    // Finds the common headroom while the block fills
    headroom_detect u_headroom_detect (
        .clk   (clk),
        .reset (reset),
        .cap   (cap_bus.sink),
        .blk   (scl_bus.detector)
    );

    // Reads the block back and scales it
    dynamic_scale u_dynamic_scale (
        .clk        (clk),
        .reset      (reset),
        .blk        (scl_bus.scaler),
        .out_req    (out_req),
        .out_sample (out_sample),
        .out_shift  (out_shift),
        .out_ack    (out_ack)
    );

endmodule

// ==== test/block_scaler_sva.sv ====
// Four-phase handshake and reset checks
// Bound once to the input side and once to the output side

module block_scaler_sva (
    input logic        clk,
    input logic        reset,
    input logic        req,
    input logic        ack,
    // Guard and sample, or shift code and sample
    input logic [28:0] payload,
    // Handshake line driven by the bound block
    input logic        drive
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions, summed up by the testbench
    int fail_count = 0;

    // Request held until acknowledged
    req_held: assert property (@(posedge clk) disable iff (reset)
        req && !ack |=> req || ack)
        else begin
            fail_count++;
            $error("req fell before ack rose");
        end

    // Ack held until the request drops
    ack_held: assert property (@(posedge clk) disable iff (reset)
        req && ack |=> ack || !req)
        else begin
            fail_count++;
            $error("ack fell before req fell");
        end

    // Payload frozen while the request stays up
    payload_stable: assert property (@(posedge clk) disable iff (reset)
        $past(req) && req |-> $stable(payload))
        else begin
            fail_count++;
            $error("payload changed while req was high");
        end

    // Handshake output idle right after reset
    reset_idle: assert property (@(posedge clk) reset |=> !drive)
        else begin
            fail_count++;
            $error("handshake output high after reset");
        end

endmodule

bind block_buffer block_scaler_sva in_sva (
    .clk     (clk),
    .reset   (reset),
    .req     (in_req),
    .ack     (in_ack),
    .payload ({2'b00, in_guard, in_sample}),
    .drive   (in_ack)
);

bind dynamic_scale block_scaler_sva out_sva (
    .clk     (clk),
    .reset   (reset),
    .req     (out_req),
    .ack     (out_ack),
    .payload ({out_shift, out_sample}),
    .drive   (out_req)
);

// ==== test/tb_block_scaler.sv ====
// Testbench for the block-floating-point normalizer
// Golden-file stimulus, randomized source and sink handshakes
// Per-block report, watchdog and closing summary

module tb_block_scaler;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   reset;
    logic                   in_req;
    scale_pkg::sample_t     in_sample;
    scale_pkg::guard_t      in_guard;
    logic                   in_ack;
    logic                   out_req;
    scale_pkg::sample_t     out_sample;
    scale_pkg::shift_code_t out_shift;
    logic                   out_ack;

    // Golden vectors, one entry per sample
    scale_pkg::guard_t      vec_guard [$];
    scale_pkg::sample_t     vec_in [$];
    scale_pkg::sample_t     vec_exp [$];
    scale_pkg::shift_code_t vec_code [$];

    int          checks;
    int          errors;
    int          blocks_done;
    int          sva_fails;
    logic [31:0] src_lfsr;
    logic [31:0] snk_lfsr;

    block_scaler_top UUT (
        .clk        (clk),
        .reset      (reset),
        .in_req     (in_req),
        .in_sample  (in_sample),
        .in_guard   (in_guard),
        .in_ack     (in_ack),
        .out_req    (out_req),
        .out_sample (out_sample),
        .out_shift  (out_shift),
        .out_ack    (out_ack)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // Two fresh bits give 0 to 3 idle cycles
    task automatic draw_idle(inout logic [31:0] st, output int n);
        st = lfsr_step(st);
        n  = st[0];
        st = lfsr_step(st);
        n  = n + 2 * st[0];
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] g;
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] c;
        fd = $fopen("test/block_scaler_golden.txt", "r");
        if (fd == 0) begin
            $display("Golden file test/block_scaler_golden.txt could not be opened");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Lines starting with # are comments
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h", g, s, e, c);
                if (n == 4) begin
                    vec_guard.push_back(scale_pkg::guard_t'(g));
                    vec_in.push_back(scale_pkg::sample_t'(s));
                    vec_exp.push_back(scale_pkg::sample_t'(e));
                    vec_code.push_back(scale_pkg::shift_code_t'(c));
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_sample(input string name, input scale_pkg::sample_t exp_v,
                                input scale_pkg::sample_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("ERR %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_shift(input string name, input scale_pkg::shift_code_t exp_v,
                               input scale_pkg::shift_code_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("ERR %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    // Source side of the input handshake
    task automatic run_source();
        int idle;
        for (int i = 0; i < vec_in.size(); i++) begin
            draw_idle(src_lfsr, idle);
            repeat (idle) @(negedge clk);
            in_sample = vec_in[i];
            in_guard  = vec_guard[i];
            in_req    = 1'b1;
            // A full buffer leaves the request waiting here
            @(negedge clk);
            while (!in_ack) @(negedge clk);
            in_req = 1'b0;
            @(negedge clk);
            while (in_ack) @(negedge clk);
        end
    endtask

    // Sink side of the output handshake
    task automatic run_sink();
        int idle;
        int blk_err;
        blk_err = 0;
        for (int i = 0; i < vec_exp.size(); i++) begin
            if (i % block_pkg::BLOCK_LEN == 0) begin
                blk_err = errors;
            end
            draw_idle(snk_lfsr, idle);
            while (!out_req) @(negedge clk);
            check_sample("out_sample", vec_exp[i], out_sample);
            check_shift("out_shift", vec_code[i], out_shift);
            // Late ack stalls the scaler and the input behind it
            repeat (idle) @(negedge clk);
            out_ack = 1'b1;
            @(negedge clk);
            while (out_req) @(negedge clk);
            out_ack = 1'b0;
            if (i % block_pkg::BLOCK_LEN == block_pkg::BLOCK_LEN - 1) begin
                blocks_done++;
                $display("Block %0d guard %0d shift code %h done, %0d mismatches",
                         blocks_done, vec_guard[i], vec_code[i], errors - blk_err);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        in_req      = 1'b0;
        in_sample   = '0;
        in_guard    = '0;
        out_ack     = 1'b0;
        checks      = 0;
        errors      = 0;
        blocks_done = 0;
        src_lfsr    = 32'hb703;
        snk_lfsr    = 32'hb703;
        load_golden();
        if (vec_in.size() == 0 || vec_in.size() % block_pkg::BLOCK_LEN != 0) begin
            $display("Golden file does not hold a whole number of blocks");
            errors++;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        fork
            run_source();
            run_sink();
        join
        sva_fails = UUT.u_block_buffer.in_sva.fail_count
                  + UUT.u_dynamic_scale.out_sva.fail_count;
        $display("Summary: %0d blocks, %0d checks, %0d mismatches, %0d assertion failures",
                 blocks_done, checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog, about 40 cycles of 4 ns per sample plus reset
    initial begin
        #1;
        #((vec_in.size() * 40 + 8) * 4);
        $display("Timeout: the output handshake did not complete in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== test/block_scaler_golden.txt ====
# guard in_sample expected_sample expected_shift_code, all hex
# eight lines per block, guard repeated on every line
# block 1 left normalization, headroom 8
0 004321 432100 18
0 000100 010000 18
0 FFF000 F00000 18
0 001234 123400 18
0 FFFFFF FFFF00 18
0 000000 000000 18
0 FFC321 C32100 18
0 002000 200000 18
# block 2 arithmetic right shift, guard 5, headroom 1
5 3FFFFF 03FFFF 04
5 C00000 FC0000 04
5 123456 012345 04
5 E87654 FE8765 04
5 000010 000001 04
5 FFFFF0 FFFFFF 04
5 2ABCDE 02ABCD 04
5 D0000F FD0000 04
# block 3 tiny samples, code clamped to -15
0 000000 000000 11
0 000001 008000 11
0 FFFFFF FF8000 11
0 000002 010000 11
0 FFFFFE FF0000 11
0 000000 000000 11
0 000003 018000 11
0 FFFFFD FE8000 11
# block 4 full scale, guard 7
7 7FFFFF 00FFFF 07
7 800000 FF0000 07
7 400000 008000 07
7 123456 002468 07
7 FFFF80 FFFFFF 07
7 000000 000000 07
7 A5A5A5 FF4B4B 07
7 0FFFFF 001FFF 07
# block 5 mixed signs, guard 2, headroom 4
2 001000 004000 1E
2 FF0000 FC0000 1E
2 00F000 03C000 1E
2 F80000 E00000 1E
2 07FFFF 1FFFFC 1E
2 FFFFFF FFFFFC 1E
2 0000FF 0003FC 1E
2 FC0001 F00004 1E
# block 6 guard equals headroom, code 0
3 0ABCDE 0ABCDE 00
3 F12345 F12345 00
3 000001 000001 00
3 FEDCBA FEDCBA 00
3 055555 055555 00
3 F80001 F80001 00
3 0FFFF0 0FFFF0 00
3 012345 012345 00

// ==== all.f ====
logic/scale_pkg.sv
logic/block_pkg.sv
logic/capture_if.sv
logic/scale_if.sv
logic/block_buffer.sv
logic/headroom_detect.sv
logic/dynamic_scale.sv
logic/block_scaler_top.sv
test/block_scaler_sva.sv
test/tb_block_scaler.sv
